// ==== hw/zeroPkg.sv ====
/*
  Shared machine definitions
  Word width default, opcode set, instruction and run status structs
*/
package zeroPkg;

  localparam int wordWidth = 12;                  // Default machine word
  localparam int addrWidth = 4;                   // Local memory address bits
  localparam int ipWidth   = 8;                   // Program address bits

  // ----------------------------------------------------------
  // Instruction set
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    opLabel  = 3'd0,                              // Jump target marker only
    opInSize = 3'd1,                              // Words left in input queue
    opJFalse = 3'd2,                              // Branch when operand is zero
    opIn     = 3'd3,                              // Take next input word
    opOut    = 3'd4,                              // Emit one word
    opJmp    = 3'd5,                              // Unconditional branch
    opHalt   = 3'd6                               // Stop the run
  } opCode;

  // One program word
  typedef struct packed {
    opCode                op;
    logic [addrWidth-1:0] dst;                    // Write target or test operand
    logic [addrWidth-1:0] src;                    // Read operand
    logic [ipWidth-1:0]   target;                 // Branch address
  } instr;

  // ----------------------------------------------------------
  // Run state seen from outside
  // ----------------------------------------------------------
  typedef struct packed {
    logic busy;                                   // Program executing
    logic finished;                               // Run over until next start
    logic halted;                                 // Ended by halt
    logic timedOut;                               // Ended by step limit
  } runStatus;

endpackage

// ==== hw/programRom.sv ====
/*
  Program ROM with the echo loop
  Combinational lookup by instruction pointer
*/
module programRom (
  input  logic [zeroPkg::ipWidth-1:0] ip,
  output zeroPkg::instr               code
);

  // Packs the fields of one instruction
  function automatic zeroPkg::instr mk(
    input zeroPkg::opCode                op,
    input logic [zeroPkg::addrWidth-1:0] dst,
    input logic [zeroPkg::addrWidth-1:0] src,
    input logic [zeroPkg::ipWidth-1:0]   target
  );
    zeroPkg::instr w;
    w.op     = op;
    w.dst    = dst;
    w.src    = src;
    w.target = target;
    return w;
  endfunction

  always_comb
  begin
    case (ip)
      8'd0:    code = mk(zeroPkg::opLabel,  4'd0, 4'd0, 8'd0);   // Loop head
      8'd1:    code = mk(zeroPkg::opInSize, 4'd0, 4'd0, 8'd0);   // Count into local 0
      8'd2:    code = mk(zeroPkg::opJFalse, 4'd0, 4'd0, 8'd8);   // Leave when count is zero
      8'd3:    code = mk(zeroPkg::opIn,     4'd1, 4'd0, 8'd0);   // Word into local 1
      8'd4:    code = mk(zeroPkg::opOut,    4'd0, 4'd0, 8'd0);   // Emit count
      8'd5:    code = mk(zeroPkg::opOut,    4'd0, 4'd1, 8'd0);   // Emit word
      8'd6:    code = mk(zeroPkg::opLabel,  4'd0, 4'd0, 8'd0);
      8'd7:    code = mk(zeroPkg::opJmp,    4'd0, 4'd0, 8'd0);   // Back to loop head
      8'd8:    code = mk(zeroPkg::opLabel,  4'd0, 4'd0, 8'd0);   // Exit path
      default: code = mk(zeroPkg::opHalt,   4'd0, 4'd0, 8'd0);   // Address 9 and beyond
    endcase
  end

endmodule

// ==== hw/localMemory.sv ====
/*
  Local word memory
  Two combinational read ports and one clocked write port
*/
module localMemory #(
  parameter int WordWidth = zeroPkg::wordWidth,
  parameter int NLocal    = 16
) (
  input  logic                      run,
  input  logic                      rstN,
  input  logic [$clog2(NLocal)-1:0] rdAddrA,
  input  logic [$clog2(NLocal)-1:0] rdAddrB,
  input  logic [$clog2(NLocal)-1:0] wrAddr,
  input  logic                      wrEn,
  input  logic [WordWidth-1:0]      wrData,
  output logic [WordWidth-1:0]      rdDataA,
  output logic [WordWidth-1:0]      rdDataB
);

  logic [WordWidth-1:0] mem [NLocal];

  assign rdDataA = mem[rdAddrA];                  // Same cycle read
  assign rdDataB = mem[rdAddrB];

  always_ff @(posedge run or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < NLocal; i++)
      begin
        mem[i] <= '0;                             // Locals start at zero
      end
    end
    else if (wrEn)
    begin
      mem[wrAddr] <= wrData;
    end
  end

endmodule

// ==== hw/inChannel.sv ====
/*
  Input word queue
  Loaded from outside, popped by in instructions, reports words left
*/
module inChannel #(
  parameter int WordWidth = zeroPkg::wordWidth,
  parameter int NIn       = 8
) (
  input  logic                 run,
  input  logic                 rstN,
  input  logic                 load,
  input  logic [WordWidth-1:0] word,
  input  logic                 pop,
  output logic [WordWidth-1:0] headWord,
  output logic [WordWidth-1:0] remaining
);

  localparam int PtrWidth   = (NIn > 1) ? $clog2(NIn) : 1;
  localparam int CountWidth = $clog2(NIn + 1);

  logic [WordWidth-1:0]  queue [NIn];
  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;
  logic                  doPush;
  logic                  doPop;

  // Wraps at the queue depth
  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] p);
    return (p == PtrWidth'(NIn - 1)) ? '0 : p + 1'b1;
  endfunction

  assign doPush    = load && (count != CountWidth'(NIn));   // Full queue drops the load
  assign doPop     = pop && (count != '0);
  assign headWord  = queue[rdPtr];
  assign remaining = WordWidth'(count);

  always_ff @(posedge run)
  begin
    if (doPush)
    begin
      queue[wrPtr] <= word;
    end
  end

  // ----------------------------------------------------------
  // Pointers and fill level
  // ----------------------------------------------------------
  always_ff @(posedge run or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                  // Both or neither
      endcase
    end
  end

endmodule

// ==== hw/executionUnit.sv ====
/*
  Execution unit
  Instruction pointer, decode and execute of one instruction per cycle
  Registered output word and strobe
*/
module executionUnit #(
  parameter int WordWidth = zeroPkg::wordWidth
) (
  input  logic                          run,
  input  logic                          rstN,
  input  logic                          enable,
  input  logic                          clear,
  output logic [zeroPkg::ipWidth-1:0]   ip,
  input  zeroPkg::instr                 code,
  output logic [zeroPkg::addrWidth-1:0] rdAddrA,
  output logic [zeroPkg::addrWidth-1:0] rdAddrB,
  output logic [zeroPkg::addrWidth-1:0] wrAddr,
  output logic                          wrEn,
  output logic [WordWidth-1:0]          wrData,
  input  logic [WordWidth-1:0]          rdDataA,
  input  logic [WordWidth-1:0]          rdDataB,
  input  logic [WordWidth-1:0]          remaining,
  input  logic [WordWidth-1:0]          headWord,
  output logic                          pop,
  output logic [WordWidth-1:0]          outWord,
  output logic                          outValid,
  output logic                          stepDone,
  output logic                          halt
);

  logic                        queueEmpty;
  logic                        isOut;
  logic [zeroPkg::ipWidth-1:0] ipNext;

  assign rdAddrA    = code.src;                   // Operand for out
  assign rdAddrB    = code.dst;                   // Operand tested by jFalse
  assign wrAddr     = code.dst;
  assign queueEmpty = (remaining == '0);
  assign isOut      = enable && (code.op == zeroPkg::opOut);
  assign stepDone   = enable && !halt;            // Halt is not a counted step

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  always_comb
  begin
    wrEn   = 1'b0;
    wrData = remaining;
    pop    = 1'b0;
    halt   = 1'b0;
    ipNext = ip + 1'b1;
    if (enable)
    begin
      case (code.op)
        zeroPkg::opInSize:
        begin
          wrEn   = 1'b1;                          // Count of words left
          wrData = remaining;
        end
        zeroPkg::opJFalse:
        begin
          if (rdDataB == '0)
          begin
            ipNext = code.target;
          end
        end
        zeroPkg::opIn:
        begin
          wrEn   = !queueEmpty;                   // Empty queue keeps the old value
          wrData = headWord;
          pop    = !queueEmpty;
        end
        zeroPkg::opJmp:
        begin
          ipNext = code.target;
        end
        zeroPkg::opHalt:
        begin
          halt   = 1'b1;
          ipNext = ip;                            // Park on the halt
        end
        default:
        begin
          ipNext = ip + 1'b1;                     // Label and out fall through
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Instruction pointer and output strobe
  // ----------------------------------------------------------
  always_ff @(posedge run or negedge rstN)
  begin
    if (!rstN)
    begin
      ip       <= '0;
      outValid <= 1'b0;
    end
    else if (clear)
    begin
      ip       <= '0;                             // Fresh run from address 0
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= isOut;                          // One cycle after the out
      if (enable)
      begin
        ip <= ipNext;
      end
    end
  end

  always_ff @(posedge run)
  begin
    if (isOut)
    begin
      outWord <= rdDataA;
    end
  end

endmodule

// ==== hw/runControl.sv ====
/*
  Run control registers
  Step limit, start and busy state, step counter and end status
*/
module runControl #(
  parameter int StepWidth = 10
) (
  input  logic                 run,
  input  logic                 rstN,
  input  logic                 start,
  input  logic [StepWidth-1:0] stepLimit,
  input  logic                 stepDone,
  input  logic                 halt,
  output logic                 enable,
  output logic                 clear,
  output logic [StepWidth-1:0] steps,
  output zeroPkg::runStatus    status
);

  logic [StepWidth-1:0] limit;
  logic                 atLimit;

  assign clear   = start && !status.busy;         // Start while busy is ignored
  assign enable  = status.busy;
  assign atLimit = (steps == limit);

  always_ff @(posedge run)
  begin
    if (clear)
    begin
      limit <= stepLimit;                         // Held for the whole run
    end
  end

  always_ff @(posedge run or negedge rstN)
  begin
    if (!rstN)
    begin
      steps  <= '0;
      status <= '0;
    end
    else if (clear)
    begin
      steps  <= '0;
      status <= '{busy: 1'b1, finished: 1'b0, halted: 1'b0, timedOut: 1'b0};
    end
    else if (status.busy)
    begin
      if (stepDone && !atLimit)
      begin
        steps <= steps + 1'b1;                    // Saturates at the limit
      end
      if (halt)
      begin
        status <= '{busy: 1'b0, finished: 1'b1, halted: 1'b1, timedOut: 1'b0};
      end
      else if (atLimit)
      begin
        status <= '{busy: 1'b0, finished: 1'b1, halted: 1'b0, timedOut: 1'b1};
      end
    end
  end

endmodule

// ==== hw/zeroMachine.sv ====
/*
  Machine top level
  ROM, local memory, input queue, execution unit and run control
*/
module zeroMachine #(
  parameter int WordWidth = zeroPkg::wordWidth,
  parameter int NLocal    = 16,
  parameter int NIn       = 8,
  parameter int StepWidth = 10
) (
  input  logic                 run,
  input  logic                 rstN,
  input  logic [WordWidth-1:0] inWord,
  input  logic                 inLoad,
  input  logic [StepWidth-1:0] stepLimit,
  input  logic                 start,
  output logic [WordWidth-1:0] outWord,
  output logic                 outValid,
  output zeroPkg::runStatus    status,
  output logic [StepWidth-1:0] steps
);

  logic [zeroPkg::ipWidth-1:0]   ip;
  zeroPkg::instr                 code;
  logic [zeroPkg::addrWidth-1:0] rdAddrA;
  logic [zeroPkg::addrWidth-1:0] rdAddrB;
  logic [zeroPkg::addrWidth-1:0] wrAddr;
  logic                          wrEn;
  logic [WordWidth-1:0]          wrData;
  logic [WordWidth-1:0]          rdDataA;
  logic [WordWidth-1:0]          rdDataB;
  logic [WordWidth-1:0]          remaining;
  logic [WordWidth-1:0]          headWord;
  logic                          pop;
  logic                          enable;
  logic                          clear;
  logic                          stepDone;
  logic                          halt;
  logic                          loadIdle;

  assign loadIdle = inLoad && !status.busy;       // Loads only between runs

  programRom i_programRom (.ip(ip), .code(code));

  localMemory #(.WordWidth(WordWidth), .NLocal(NLocal)) i_localMemory (
    .run(run), .rstN(rstN), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .wrAddr(wrAddr),
    .wrEn(wrEn), .wrData(wrData), .rdDataA(rdDataA), .rdDataB(rdDataB)
  );

  inChannel #(.WordWidth(WordWidth), .NIn(NIn)) i_inChannel (
    .run(run), .rstN(rstN), .load(loadIdle), .word(inWord), .pop(pop),
    .headWord(headWord), .remaining(remaining)
  );

  executionUnit #(.WordWidth(WordWidth)) i_executionUnit (
    .run(run), .rstN(rstN), .enable(enable), .clear(clear), .ip(ip), .code(code),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .wrAddr(wrAddr), .wrEn(wrEn), .wrData(wrData),
    .rdDataA(rdDataA), .rdDataB(rdDataB), .remaining(remaining), .headWord(headWord),
    .pop(pop), .outWord(outWord), .outValid(outValid), .stepDone(stepDone), .halt(halt)
  );

  runControl #(.StepWidth(StepWidth)) i_runControl (
    .run(run), .rstN(rstN), .start(start), .stepLimit(stepLimit), .stepDone(stepDone),
    .halt(halt), .enable(enable), .clear(clear), .steps(steps), .status(status)
  );

endmodule

// ==== sim/zeroMachineTb.sv ====
/*
  Testbench for the echo machine
  Clock, reset, LFSR stimulus, output scoreboard, assertions and report
*/
module zeroMachineTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WordWidth = zeroPkg::wordWidth;
  localparam int StepWidth = 10;
  localparam int NPhases   = 8;                   // Loads and runs issued below
  localparam int MaxCycles = 8 + 64 * NPhases;
  localparam logic [StepWidth-1:0] NoLimit = 10'd1000;

  logic                 run;
  logic                 rstN;
  logic [WordWidth-1:0] inWord;
  logic                 inLoad;
  logic [StepWidth-1:0] stepLimit;
  logic                 start;
  logic [WordWidth-1:0] outWord;
  logic                 outValid;
  zeroPkg::runStatus    status;
  logic [StepWidth-1:0] steps;

  logic [WordWidth-1:0] expQ [$];                 // Expected outputs in order
  logic [WordWidth-1:0] modelQ [$];               // Words the DUT should still hold
  logic [15:0]          lfsr;
  int                   errors;
  int                   testErrors;
  int                   testsRun;
  int                   testsFailed;
  int                   cycles;
  int                   leftover;

  zeroMachine #(.WordWidth(WordWidth), .NLocal(16), .NIn(8), .StepWidth(StepWidth)) i_dut (
    .run(run), .rstN(rstN), .inWord(inWord), .inLoad(inLoad), .stepLimit(stepLimit),
    .start(start), .outWord(outWord), .outValid(outValid), .status(status), .steps(steps)
  );

  always #5 run = ~run;

  always @(posedge run)
  begin
    cycles++;
    if (cycles > MaxCycles)
    begin
      $display("Run stopped after %0d cycles with the DUT still not finished", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  endReason: assert property (@(posedge run) disable iff (!rstN)
    status.finished |-> !status.busy && (status.halted != status.timedOut))
  else
  begin
    errors++;
    $display("Run finished at %0t without exactly one end reason", $time);
  end

  keepFinished: assert property (@(posedge run) disable iff (!rstN)
    $past(status.finished) && !status.busy |-> status.finished)
  else
  begin
    errors++;
    $display("Finished flag dropped at %0t without a new start", $time);
  end

  stepBound: assert property (@(posedge run) disable iff (!rstN)
    status.busy |-> steps <= stepLimit)
  else
  begin
    errors++;
    $display("ERROR %0t steps got %0d expected at most %0d", $time, steps, stepLimit);
  end

  limitStop: assert property (@(posedge run) disable iff (!rstN)
    $rose(status.timedOut) |-> steps == stepLimit)
  else
  begin
    errors++;
    $display("ERROR %0t steps got %0d expected %0d", $time, steps, stepLimit);
  end

  // Scoreboard sampled mid cycle
  always @(negedge run)
  begin
    if (rstN && outValid)
    begin
      outExpected: assert (expQ.size() != 0)
      else
      begin
        errors++;
        $display("Output %h at %0t came with no output expected", outWord, $time);
      end
      if (expQ.size() != 0)
      begin
        outMatch: assert (outWord == expQ[0])
        else
        begin
          errors++;
          $display("ERROR %0t outWord got %h expected %h", $time, outWord, expQ[0]);
        end
        void'(expQ.pop_front());
      end
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic drawWord(output logic [WordWidth-1:0] w);
    w = '0;
    for (int i = 0; i < WordWidth; i++)
    begin
      w    = {w[WordWidth-2:0], lfsr[0]};     // One step per bit
      lfsr = lfsrStep(lfsr);
    end
  endtask

  task automatic checkValue(input string name, input int got, input int exp);
    valueCheck: assert (got == exp)
    else
    begin
      errors++;
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic loadWords(input int n);
    logic [WordWidth-1:0] w;
    for (int i = 0; i < n; i++)
    begin
      drawWord(w);
      @(negedge run);
      inWord = w;
      inLoad = 1'b1;
      modelQ.push_back(w);
    end
    @(negedge run);
    inLoad = 1'b0;
  endtask

  // Count then word per loop and only the count for a partial loop
  task automatic expectEcho(input int iters, input bit partial);
    for (int i = 0; i < iters; i++)
    begin
      expQ.push_back(WordWidth'(modelQ.size()));
      expQ.push_back(modelQ.pop_front());
    end
    if (partial)
    begin
      expQ.push_back(WordWidth'(modelQ.size()));
      void'(modelQ.pop_front());                // Taken by in and never sent out
    end
  endtask

  task automatic startRun(input logic [StepWidth-1:0] limit);
    @(negedge run);
    stepLimit = limit;
    start     = 1'b1;
    @(negedge run);
    start     = 1'b0;
  endtask

  task automatic finishRun(input int expSteps, input bit expHalted);
    while (!status.finished)
    begin
      @(negedge run);
    end
    @(negedge run);                             // Last output pulse drains
    checkValue("steps", int'(steps), expSteps);
    checkValue("halted", int'(status.halted), int'(expHalted));
    checkValue("timedOut", int'(status.timedOut), int'(!expHalted));
    queueDrained: assert (expQ.size() == 0)
    else
    begin
      errors++;
      $display("%0d expected outputs never appeared by %0t", expQ.size(), $time);
    end
    expQ.delete();
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errors == testErrors)
    begin
      $display("[%0d] %s: pass", testsRun, name);
    end
    else
    begin
      testsFailed++;
      $display("[%0d] %s: %0d errors", testsRun, name, errors - testErrors);
    end
    testErrors = errors;
  endtask

  // ------------------------------------------------------------
  // Sequence of tests
  // ------------------------------------------------------------
  initial
  begin
    run         = 1'b0;
    rstN        = 1'b0;
    inWord      = '0;
    inLoad      = 1'b0;
    stepLimit   = NoLimit;
    start       = 1'b0;
    lfsr        = 16'd20629;
    errors      = 0;
    testErrors  = 0;
    testsRun    = 0;
    testsFailed = 0;
    cycles      = 0;
    repeat (8) @(negedge run);
    rstN = 1'b1;

    @(negedge run);
    checkValue("outValid", int'(outValid), 0);
    checkValue("busy", int'(status.busy), 0);
    checkValue("finished", int'(status.finished), 0);
    checkValue("steps", int'(steps), 0);
    endTest("state after reset");

    loadWords(3);
    expectEcho(3, 1'b0);
    startRun(NoLimit);
    finishRun(28, 1'b1);
    endTest("echo of three words");

    startRun(NoLimit);
    finishRun(4, 1'b1);
    endTest("empty queue halts at once");

    loadWords(8);
    expectEcho(2, 1'b1);
    startRun(10'd20);
    finishRun(20, 1'b0);
    endTest("step limit cuts eight words");

    leftover = modelQ.size();
    expectEcho(leftover, 1'b0);
    startRun(NoLimit);
    finishRun(8 * leftover + 4, 1'b1);
    endTest("leftover words drained");

    loadWords(3);
    expectEcho(3, 1'b0);
    startRun(NoLimit);
    @(negedge run);
    checkValue("busy", int'(status.busy), 1);
    drawWord(inWord);
    inLoad = 1'b1;                              // Both must be ignored while busy
    start  = 1'b1;
    @(negedge run);
    inLoad = 1'b0;
    start  = 1'b0;
    finishRun(28, 1'b1);
    endTest("load and start ignored while busy");

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hw/zeroPkg.sv
hw/programRom.sv
hw/localMemory.sv
hw/inChannel.sv
hw/executionUnit.sv
hw/runControl.sv
hw/zeroMachine.sv
sim/zeroMachineTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the echo machine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sim.f \
  --top-module zeroMachineTb \
  -o zeroMachineSim

out=$(./obj_dir/zeroMachineSim)
echo "$out"

# Exit status follows the pass line
echo "$out" | grep -q "^Test OK$"
